/* Bender.yml */
package:
  name: integ

sources:
  - logic/integ_pkg.sv
  - logic/integ_regs.sv
  - logic/booth_mult.sv
  - logic/seq_div.sv
  - logic/integ_step.sv
  - logic/integ_top.sv
  - target: simulation
    files:
      - dv/integ_checker.sv
      - dv/integ_tb.sv

/* dv/integ_checker.sv */
`timescale 1ns/1ps

module integ_checker
    import integ_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input axil_req_t s_axil_req,
    input axil_rsp_t s_axil_rsp,
    input logic      busy
);

    // Failed assertions, read back by the testbench
    int fail_count = 0;

    bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_rsp.bvalid && !s_axil_req.bready |=> s_axil_rsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_axil_rsp.rvalid && !s_axil_req.rready |=>
            s_axil_rsp.rvalid && $stable(s_axil_rsp.rdata))
    else begin
        $error("rvalid dropped or rdata changed before rready");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
    else begin
        $error("busy high on the cycle after reset");
        fail_count++;
    end

    // Sample writes are held off while a step runs
    no_sample_while_busy: assert property (@(posedge clk) disable iff (rst)
        !(s_axil_rsp.awready && busy && s_axil_req.awaddr == REG_SAMPLE))
    else begin
        $error("sample write accepted while busy");
        fail_count++;
    end

endmodule

bind integ_top integ_checker chk0 (.*);

/* dv/integ_tb.sv */
`timescale 1ns/1ps

module integ_tb
    import integ_pkg::*;
();

    localparam int WAIT_MAX = 1000;

    logic             clk;
    logic             rst;
    axil_req_t        req;
    axil_rsp_t        rsp;
    logic             busy;
    logic [31:0]      lcg_state;
    logic [ACC_W-1:0] acc_model;
    int               checks;
    int               errors;
    int               err_mark;
    int               test_num;

    integ_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .s_axil_req (req),
        .s_axil_rsp (rsp),
        .busy       (busy)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Reference step adds floor(|a*dt| * 2^32 / scale) with the product's sign
    function automatic void model_step(logic signed [15:0] a, logic [15:0] dt);
        logic signed [31:0] prod;
        logic [63:0]        mag;
        prod = a * $signed({1'b0, dt});
        mag  = prod < 0 ? -prod : prod;
        mag  = (mag << 32) / 64'd100_000_000;
        acc_model = prod < 0 ? acc_model - mag : acc_model + mag;
    endfunction

    task automatic expect_eq(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, what, exp, got);
            errors++;
        end
    endtask

    //////////////////////////////
    // AXI4-Lite access
    //////////////////////////////

    // Polls at falling edges until the response channel is valid
    task automatic wait_rsp(bit rd, string what);
        int n = 0;
        while (!(rd ? rsp.rvalid : rsp.bvalid) && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!(rd ? rsp.rvalid : rsp.bvalid)) begin
            $display("Timeout: no %s response from the DUT", what);
            errors++;
        end
    endtask

    task automatic axil_write(logic [7:0] addr, logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        req.awaddr  = addr;
        req.wdata   = data;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        @(negedge clk);
        wait_rsp(1'b0, "write");
        resp        = rsp.bresp;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        // Response left waiting one cycle before bready
        @(negedge clk);
        req.bready = 1'b1;
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic axil_read(logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        @(negedge clk);
        wait_rsp(1'b1, "read");
        data        = rsp.rdata;
        resp        = rsp.rresp;
        req.arvalid = 1'b0;
        // Read data left waiting one cycle before rready
        @(negedge clk);
        req.rready = 1'b1;
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic [1:0]  r;
        int          n;
        n  = 0;
        st = 32'd1;
        while (st[0] && n < WAIT_MAX) begin
            axil_read(REG_STATUS, st, r);
            n++;
        end
        if (st[0]) begin
            $display("Timeout: busy flag never cleared");
            errors++;
        end else begin
            expect_eq("busy output", 32'(busy), 32'd0);
        end
    endtask

    //////////////////////////////
    // Step helpers
    //////////////////////////////

    task automatic check_acc();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [1:0]  r_hi;
        logic [1:0]  r_lo;
        axil_read(REG_ACC_HI, hi, r_hi);
        axil_read(REG_ACC_LO, lo, r_lo);
        expect_eq("ACC responses", {r_hi, r_lo}, 32'd0);
        expect_eq("ACC_HI", hi, acc_model[63:32]);
        expect_eq("ACC_LO", lo, acc_model[31:0]);
    endtask

    task automatic send_sample(logic signed [15:0] a, logic [15:0] dt);
        logic [1:0] r;
        model_step(a, dt);
        axil_write(REG_SAMPLE, {dt, a}, r);
        expect_eq("SAMPLE response", r, RESP_OKAY);
    endtask

    task automatic run_step(logic signed [15:0] a, logic [15:0] dt);
        send_sample(a, dt);
        wait_idle();
        check_acc();
    endtask

    task automatic test_done(string name);
        test_num++;
        $display("Test %0d %s: %s", test_num, name, errors == err_mark ? "ok" : "errors");
        err_mark = errors;
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0]  r;
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        lcg_state = 32'd72;
        acc_model = '0;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        test_num  = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        check_acc();
        axil_read(REG_STATUS, d, r);
        expect_eq("STATUS", d, 32'd0);
        expect_eq("STATUS response", r, RESP_OKAY);
        test_done("reset values");

        run_step(16'sd1000, 16'd50000);
        test_done("positive step");

        run_step(-16'sd1000, 16'd50000);
        run_step(-16'sd32768, 16'd65535);
        test_done("negative steps");

        repeat (20) begin
            d = lcg_next();
            run_step(d[31:16], 16'(lcg_next() >> 16));
        end
        test_done("random steps");

        // Second write stalls until the first step ends
        send_sample(16'sd12345, 16'd40000);
        send_sample(-16'sd777, 16'd999);
        wait_idle();
        check_acc();
        axil_write(REG_CTRL, 32'd1, r);
        acc_model = '0;
        expect_eq("CTRL response", r, RESP_OKAY);
        check_acc();
        test_done("back-pressure and clear");

        run_step(16'sd2222, 16'd3333);
        axil_write(8'h14, 32'hFFFF_FFFF, r);
        expect_eq("write 0x14 response", r, RESP_SLVERR);
        axil_write(REG_ACC_HI, 32'hFFFF_FFFF, r);
        expect_eq("write ACC_HI response", r, RESP_SLVERR);
        axil_read(REG_SAMPLE, d, r);
        expect_eq("read SAMPLE response", r, RESP_SLVERR);
        expect_eq("read SAMPLE data", d, 32'd0);
        check_acc();
        test_done("bad accesses");

        errors = errors + dut0.chk0.fail_count;
        $display("Tests: %0d, checks: %0d, failures: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/integ_pkg.sv
logic/integ_regs.sv
logic/booth_mult.sv
logic/seq_div.sv
logic/integ_step.sv
logic/integ_top.sv
dv/integ_checker.sv
dv/integ_tb.sv

/* logic/booth_mult.sv */
`timescale 1ns/1ps

module booth_mult (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic signed [15:0] multiplicand,
    input  logic signed [15:0] multiplier,
    output logic signed [31:0] product,
    output logic               done
);

    logic               running;
    logic [4:0]         count;

    // Partial product, upper half one bit wider for the add
    logic signed [16:0] hi;
    logic        [15:0] lo;
    logic               q_m1;
    logic signed [15:0] mcand;

    logic signed [16:0] hi_cur;
    logic        [15:0] lo_cur;
    logic               qm_cur;
    logic signed [15:0] m_cur;
    logic signed [16:0] m_ext;
    logic signed [16:0] sum;

    // First recoding step runs on the start edge
    always_comb begin
        hi_cur = start ? '0 : hi;
        lo_cur = start ? multiplier : lo;
        qm_cur = start ? 1'b0 : q_m1;
        m_cur  = start ? multiplicand : mcand;
        m_ext  = {m_cur[15], m_cur};
        case ({lo_cur[0], qm_cur})
            2'b01:   sum = hi_cur + m_ext;
            2'b10:   sum = hi_cur - m_ext;
            default: sum = hi_cur;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= 5'd15;
            end else if (running) begin
                count <= count - 5'd1;
                if (count == 5'd1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Arithmetic shift right of the whole partial product
    always_ff @(posedge clk) begin
        if (start || running) begin
            hi    <= {sum[16], sum[16:1]};
            lo    <= {sum[0], lo_cur[15:1]};
            q_m1  <= lo_cur[0];
            mcand <= m_cur;
        end
    end

    // Digit for the zero sign bit above dt, +multiplicand at weight 2^16
    assign product = {hi[15:0] + (q_m1 ? mcand : 16'sd0), lo};

endmodule

/* logic/integ_pkg.sv */
package integ_pkg;

    //////////////////////////////
    // AXI4-Lite bus
    //////////////////////////////

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    // Master side of the bus
    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] awaddr;
        logic                   awvalid;
        logic [AXIL_DATA_W-1:0] wdata;
        logic                   wvalid;
        logic                   bready;
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //////////////////////////////
    // Register map
    //////////////////////////////

    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 8'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_SAMPLE = 8'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_ACC_HI = 8'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_ACC_LO = 8'h10;

    // One sample word, dt in the upper half
    typedef struct packed {
        logic        [15:0] dt;
        logic signed [15:0] a;
    } step_cmd_t;

    //////////////////////////////
    // Arithmetic
    //////////////////////////////

    // Ticks per time unit
    localparam logic [31:0] TIME_SCALE = 32'd100_000_000;

    localparam int ACC_W   = 64;
    // Product magnitude with 32 fraction bits appended
    localparam int DIV_N_W = 96;
    localparam int DIV_Q_W = 64;

endpackage

/* logic/integ_regs.sv */
`timescale 1ns/1ps

module integ_regs
    import integ_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  axil_req_t        s_axil_req,
    output axil_rsp_t        s_axil_rsp,
    input  logic             busy,
    input  logic [ACC_W-1:0] acc,
    output step_cmd_t        cmd,
    output logic             cmd_valid,
    output logic             clear
);

    logic                   wr_is_ctrl;
    logic                   wr_is_sample;
    logic                   wr_ctl;
    logic                   wr_ok;
    logic                   wr_go;
    logic                   ar_go;

    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   r_valid;
    logic [1:0]             r_resp;
    logic [AXIL_DATA_W-1:0] r_data;

    //////////////////////////////
    // Write channel
    //////////////////////////////

    assign wr_is_ctrl   = s_axil_req.awaddr == REG_CTRL;
    assign wr_is_sample = s_axil_req.awaddr == REG_SAMPLE;
    assign wr_ctl       = wr_is_ctrl || wr_is_sample;

    // Control writes wait for the running step to finish
    assign wr_ok = !(wr_ctl && busy);

    // AW and W taken together, one write response outstanding at most
    assign wr_go = s_axil_req.awvalid && s_axil_req.wvalid && !b_valid && wr_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid   <= 1'b0;
            cmd_valid <= 1'b0;
            clear     <= 1'b0;
        end else begin
            cmd_valid <= wr_go && wr_is_sample;
            clear     <= wr_go && wr_is_ctrl && s_axil_req.wdata[0];
            if (wr_go) begin
                b_valid <= 1'b1;
            end else if (s_axil_req.bready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            b_resp <= wr_ctl ? RESP_OKAY : RESP_SLVERR;
            if (wr_is_sample) begin
                cmd <= step_cmd_t'(s_axil_req.wdata);
            end
        end
    end

    //////////////////////////////
    // Read channel
    //////////////////////////////

    assign ar_go = s_axil_req.arvalid && !r_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (ar_go) begin
            r_valid <= 1'b1;
        end else if (s_axil_req.rready) begin
            r_valid <= 1'b0;
        end
    end

    // Data latched at AR acceptance, held while rvalid is up
    always_ff @(posedge clk) begin
        if (ar_go) begin
            r_resp <= RESP_OKAY;
            case (s_axil_req.araddr)
                REG_STATUS: r_data <= {{(AXIL_DATA_W-1){1'b0}}, busy};
                REG_ACC_HI: r_data <= acc[ACC_W-1:32];
                REG_ACC_LO: r_data <= acc[31:0];
                default: begin
                    // Write-only or unmapped
                    r_data <= '0;
                    r_resp <= RESP_SLVERR;
                end
            endcase
        end
    end

    always_comb begin
        s_axil_rsp.awready = wr_go;
        s_axil_rsp.wready  = wr_go;
        s_axil_rsp.bresp   = b_resp;
        s_axil_rsp.bvalid  = b_valid;
        s_axil_rsp.arready = ar_go;
        s_axil_rsp.rdata   = r_data;
        s_axil_rsp.rresp   = r_resp;
        s_axil_rsp.rvalid  = r_valid;
    end

endmodule

/* logic/integ_step.sv */
`timescale 1ns/1ps

module integ_step
    import integ_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  step_cmd_t        cmd,
    input  logic             cmd_valid,
    input  logic             clear,
    output logic             busy,
    output logic [ACC_W-1:0] acc
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MUL,
        S_MAG,
        S_DIV,
        S_ACC
    } state_t;

    state_t              state;

    logic                mul_start;
    logic                mul_done;
    logic signed [31:0]  product;

    logic                div_start;
    logic                div_done;
    logic [DIV_Q_W-1:0]  quotient;

    // Product magnitude and its sign
    logic [31:0]         mag;
    logic                neg;

    assign busy      = state != S_IDLE;
    assign mul_start = cmd_valid && state == S_IDLE;
    assign div_start = state == S_MAG;

    booth_mult mult0 (
        .clk          (clk),
        .rst          (rst),
        .start        (mul_start),
        .multiplicand (cmd.a),
        .multiplier   ($signed(cmd.dt)),
        .product      (product),
        .done         (mul_done)
    );

    // Magnitude scaled by 2^32, over the time scale
    seq_div div0 (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend ({32'd0, mag, 32'd0}),
        .divisor  (TIME_SCALE),
        .quotient (quotient),
        .done     (div_done)
    );

    always_ff @(posedge clk) begin
        if (state == S_MUL && mul_done) begin
            neg <= product[31];
            mag <= product[31] ? ~product + 32'd1 : product;
        end
    end

    //////////////////////////////
    // Step sequencing and result
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            acc   <= '0;
        end else begin
            case (state)
                S_IDLE: if (cmd_valid) state <= S_MUL;
                S_MUL:  if (mul_done) state <= S_MAG;
                S_MAG:  state <= S_DIV;
                S_DIV:  if (div_done) state <= S_ACC;
                S_ACC: begin
                    // Wraps modulo 2^64
                    acc   <= neg ? acc - quotient : acc + quotient;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
            // Only arrives while idle
            if (clear) begin
                acc <= '0;
            end
        end
    end

endmodule

/* logic/integ_top.sv */
`timescale 1ns/1ps

module integ_top
    import integ_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t s_axil_req,
    output axil_rsp_t s_axil_rsp,
    output logic      busy
);

    step_cmd_t        cmd;
    logic             cmd_valid;
    logic             clear;
    logic [ACC_W-1:0] acc;

    // Decode
    integ_regs regs0 (
        .clk        (clk),
        .rst        (rst),
        .s_axil_req (s_axil_req),
        .s_axil_rsp (s_axil_rsp),
        .busy       (busy),
        .acc        (acc),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .clear      (clear)
    );

    // Execute and result
    integ_step step0 (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .clear     (clear),
        .busy      (busy),
        .acc       (acc)
    );

endmodule

/* logic/seq_div.sv */
`timescale 1ns/1ps

module seq_div
    import integ_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [DIV_N_W-1:0] dividend,
    input  logic [31:0]        divisor,
    output logic [DIV_Q_W-1:0] quotient,
    output logic               done
);

    logic               running;
    // Iterations left, 96 fits in 7 bits
    logic [6:0]         count;

    // Dividend shifts out at the top, quotient bits enter at the bottom
    logic [DIV_N_W-1:0] num;
    logic [31:0]        rem;
    logic [31:0]        den;

    logic [DIV_N_W-1:0] num_cur;
    logic [31:0]        rem_cur;
    logic [31:0]        den_cur;
    logic [33:0]        diff;
    logic               q_bit;

    always_comb begin
        num_cur = start ? dividend : num;
        rem_cur = start ? '0 : rem;
        den_cur = start ? divisor : den;
        // Trial subtract of the divisor from the shifted remainder
        diff  = {1'b0, rem_cur, num_cur[DIV_N_W-1]} - {2'b00, den_cur};
        q_bit = !diff[33];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= 7'(DIV_N_W - 1);
            end else if (running) begin
                count <= count - 7'd1;
                if (count == 7'd1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            den <= divisor;
        end
        if (start || running) begin
            num <= {num_cur[DIV_N_W-2:0], q_bit};
            // Restore on a failed subtract
            rem <= q_bit ? diff[31:0] : {rem_cur[30:0], num_cur[DIV_N_W-1]};
        end
    end

    // Upper quotient bits are always zero for the project's operands
    assign quotient = num[DIV_Q_W-1:0];

endmodule
